// File: Bender.yml
package:
  name: id_stage

sources:
  - id_pkg.sv
  - bypass_if.sv
  - id_ctrl.sv
  - id_imm_gen.sv
  - id_operand_fwd.sv
  - id_branch_unit.sv
  - id_stage.sv
  - target: test
    files:
      - id_monitor.sv
      - id_stage_chk.sv
      - tb_id_stage.sv

// File: build.f
id_pkg.sv
bypass_if.sv
id_ctrl.sv
id_imm_gen.sv
id_operand_fwd.sv
id_branch_unit.sv
id_stage.sv
id_monitor.sv
id_stage_chk.sv
tb_id_stage.sv

// File: bypass_if.sv
`timescale 1ns/1ps

// Write-back and load info of one later stage, looped back to decode
interface bypass_if import id_pkg::*; ();

  logic      wreg;
  reg_addr_t rd;
  word_t     data;
  logic      memrd; // Stage holds a load

  modport src (
    output wreg, rd, data, memrd
  );

  modport dst (
    input wreg, rd, data, memrd
  );

endinterface

// File: id_branch_unit.sv
`timescale 1ns/1ps

module id_branch_unit import id_pkg::*; (
  input  ctrl_t      ctrl_i,
  input  logic [2:0] funct3_i,
  input  word_t      pc_i,
  input  word_t      rs1_i,
  input  word_t      rs2_i,
  input  word_t      imm_i,
  output logic       taken_o,
  output word_t      target_o,
  output word_t      link_o
);

  logic cond;
  logic jump;

  always_comb begin
    case (funct3_i)
      F3_BEQ:  cond = (rs1_i == rs2_i);
      F3_BNE:  cond = (rs1_i != rs2_i);
      F3_BLT:  cond = ($signed(rs1_i) < $signed(rs2_i));
      F3_BGE:  cond = ($signed(rs1_i) >= $signed(rs2_i));
      F3_BLTU: cond = (rs1_i < rs2_i);
      F3_BGEU: cond = (rs1_i >= rs2_i);
      default: cond = 1'b0;
    endcase
  end

  assign jump    = ctrl_i.is_jal || ctrl_i.is_jalr;
  assign taken_o = jump || (ctrl_i.is_branch && cond);

  always_comb begin
    if (ctrl_i.is_jalr) begin
      target_o = rs1_i + imm_i;
    end else if (ctrl_i.is_jal || ctrl_i.is_branch) begin
      target_o = pc_i + imm_i;
    end else begin
      target_o = '0;
    end
  end

  assign link_o = jump ? (pc_i + PC_STEP) : '0; // Return address for rd

endmodule

// File: id_ctrl.sv
`timescale 1ns/1ps

module id_ctrl import id_pkg::*; (
  input  word_t     inst_i,
  input  logic      squash_i,
  output ctrl_t     ctrl_o,
  output reg_addr_t rs1_o,
  output reg_addr_t rs2_o,
  output reg_addr_t rd_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;  // inst[30], SUB / SRA
  logic       mext; // funct7[0] on OP, multiply group

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign alt    = inst_i[30];
  assign mext   = inst_i[25];

  function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub_ok,
                                         input logic alt_bit);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = (sub_ok && alt_bit) ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt_bit ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      F3_AND:  op = ALU_AND;
      default: op = ALU_NONE;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl_o         = '0;
    ctrl_o.imm_fmt = IMM_NONE;
    if (!squash_i) begin
      case (opcode)
        OPC_LUI: begin
          ctrl_o.alu_op  = ALU_ADD; // rs1 unread gives zero
          ctrl_o.src2    = SRC2_IMM;
          ctrl_o.imm_fmt = IMM_U;
          ctrl_o.wreg    = 1'b1;
        end
        OPC_AUIPC: begin
          ctrl_o.alu_op  = ALU_ADD;
          ctrl_o.src1    = SRC1_PC;
          ctrl_o.src2    = SRC2_IMM;
          ctrl_o.imm_fmt = IMM_U;
          ctrl_o.wreg    = 1'b1;
        end
        OPC_JAL: begin
          ctrl_o.alu_op  = ALU_LINK;
          ctrl_o.imm_fmt = IMM_J;
          ctrl_o.wreg    = 1'b1;
          ctrl_o.is_jal  = 1'b1;
        end
        OPC_JALR: begin
          ctrl_o.alu_op  = ALU_LINK;
          ctrl_o.imm_fmt = IMM_I;
          ctrl_o.wreg    = 1'b1;
          ctrl_o.rs1_rd  = 1'b1;
          ctrl_o.is_jalr = 1'b1;
        end
        OPC_BRANCH: begin
          ctrl_o.alu_op    = ALU_ADD;
          ctrl_o.imm_fmt   = IMM_B;
          ctrl_o.rs1_rd    = 1'b1;
          ctrl_o.rs2_rd    = 1'b1;
          ctrl_o.is_branch = 1'b1;
        end
        OPC_LOAD: begin
          ctrl_o.alu_op  = ALU_ADD; // Address calc
          ctrl_o.src2    = SRC2_IMM;
          ctrl_o.imm_fmt = IMM_I;
          ctrl_o.wreg    = 1'b1;
          ctrl_o.rs1_rd  = 1'b1;
          ctrl_o.memrd   = 1'b1;
          ctrl_o.mem2reg = 1'b1;
        end
        OPC_STORE: begin
          ctrl_o.alu_op  = ALU_ADD;
          ctrl_o.src2    = SRC2_IMM;
          ctrl_o.imm_fmt = IMM_S;
          ctrl_o.rs1_rd  = 1'b1;
          ctrl_o.rs2_rd  = 1'b1;
          ctrl_o.memwr   = 1'b1;
        end
        OPC_OPIMM: begin
          ctrl_o.alu_op  = alu_decode(funct3, 1'b0, alt);
          ctrl_o.src2    = SRC2_IMM;
          ctrl_o.imm_fmt = IMM_I;
          ctrl_o.wreg    = 1'b1;
          ctrl_o.rs1_rd  = 1'b1;
        end
        OPC_OP: begin
          // Multiply group passes through as a no-op bundle
          if (!mext) begin
            ctrl_o.alu_op = alu_decode(funct3, 1'b1, alt);
            ctrl_o.wreg   = 1'b1;
            ctrl_o.rs1_rd = 1'b1;
            ctrl_o.rs2_rd = 1'b1;
          end
        end
        default: ; // FENCE, SYSTEM and unknown, no effect
      endcase
    end
  end

  assign rs1_o = ctrl_o.rs1_rd ? inst_i[19:15] : '0;
  assign rs2_o = ctrl_o.rs2_rd ? inst_i[24:20] : '0;
  assign rd_o  = ctrl_o.wreg   ? inst_i[11:7]  : '0;

endmodule

// File: id_imm_gen.sv
`timescale 1ns/1ps

module id_imm_gen import id_pkg::*; (
  input  word_t    inst_i,
  input  imm_fmt_e fmt_i,
  output word_t    imm_o
);

  logic sgn;

  assign sgn = inst_i[31];

  always_comb begin
    case (fmt_i)
      IMM_I: imm_o = {{20{sgn}}, inst_i[31:20]};
      IMM_S: imm_o = {{20{sgn}}, inst_i[31:25], inst_i[11:7]};
      IMM_B: begin
        imm_o = {{19{sgn}}, sgn, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
      end
      IMM_U: imm_o = {inst_i[31:12], 12'b0};
      IMM_J: begin
        // Scrambled 20-bit offset, bit 0 implied zero
        imm_o = {{11{sgn}}, sgn, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
      end
      default: imm_o = '0;
    endcase
  end

endmodule

// File: id_monitor.sv
`timescale 1ns/1ps

module id_monitor import id_pkg::*; (
  input logic       clk_i,
  input logic       arst_n_i,
  input logic       in_valid_i,
  input word_t      pc_i,
  input word_t      inst_i,
  input word_t      rf_rs1_data_i,
  input word_t      rf_rs2_data_i,
  input logic       ex_wreg_i,
  input reg_addr_t  ex_rd_i,
  input word_t      ex_data_i,
  input logic       ex_memrd_i,
  input logic       mem_wreg_i,
  input reg_addr_t  mem_rd_i,
  input word_t      mem_data_i,
  input logic       mem_memrd_i,
  input reg_addr_t  rf_rs1_addr_o,
  input reg_addr_t  rf_rs2_addr_o,
  input logic       rf_rs1_read_o,
  input logic       rf_rs2_read_o,
  input logic       stall_o,
  input logic       branch_taken_o,
  input word_t      branch_target_o,
  input logic       ex_valid_o,
  input alu_op_e    ex_alu_op_o,
  input src1_e      ex_src1_o,
  input src2_e      ex_src2_o,
  input word_t      ex_imm_o,
  input word_t      ex_rs1_data_o,
  input word_t      ex_rs2_data_o,
  input reg_addr_t  ex_rd_o,
  input logic       ex_wreg_o,
  input logic       ex_memrd_o,
  input logic       ex_memwr_o,
  input logic       ex_mem2reg_o,
  input logic [2:0] ex_funct3_o,
  input word_t      ex_link_o
);

  typedef struct {
    logic       valid;
    logic [3:0] alu;
    logic       src1, src2, wreg, memrd, memwr, mem2reg;
    logic       rs1r, rs2r, taken, stall;
    word_t      imm, rs1d, rs2d, link, target;
    reg_addr_t  rd, rs1a, rs2a;
    logic [2:0] f3;
  } exp_t;

  int   errs = 0;
  int   checks = 0;
  exp_t cur;
  exp_t q;        // Expected ID/EX register contents
  logic squash_m;
  logic accept;

  function automatic logic [3:0] alu_of(logic [2:0] f3, logic alt, logic sub_ok);
    case (f3)
      F3_ADD:  return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
      F3_SLL:  return ALU_SLL;
      F3_SLT:  return ALU_SLT;
      F3_SLTU: return ALU_SLTU;
      F3_XOR:  return ALU_XOR;
      F3_SR:   return alt ? ALU_SRA : ALU_SRL;
      F3_OR:   return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Forwarding priority EX over MEM over register file
  function automatic word_t operand(logic rd_en, reg_addr_t idx, word_t rf);
    if (!rd_en) return '0;
    if (ex_wreg_i && ex_rd_i != 0 && ex_rd_i == idx) return ex_data_i;
    if (mem_wreg_i && mem_rd_i != 0 && mem_rd_i == idx) return mem_data_i;
    return rf;
  endfunction

  function automatic logic load_use(logic rd_en, reg_addr_t idx);
    return rd_en && ((ex_wreg_i && ex_memrd_i && ex_rd_i == idx) ||
                     (mem_wreg_i && mem_memrd_i && mem_rd_i == idx));
  endfunction

  function automatic exp_t reference(word_t inst, word_t pc, logic squash);
    exp_t e;
    int   fmt;  // 0 none, 1 I, 2 S, 3 B, 4 U, 5 J
    logic br, jal, jalr, cond;
    e = '{default: '0};
    fmt = 0;
    br = 0;
    jal = 0;
    jalr = 0;
    e.f3 = inst[14:12];
    if (!squash) begin
      case (inst[6:0])
        OPC_LUI: begin
          e.alu = ALU_ADD;
          e.src2 = 1;
          fmt = 4;
          e.wreg = 1;
        end
        OPC_AUIPC: begin
          e.alu = ALU_ADD;
          e.src1 = 1;
          e.src2 = 1;
          fmt = 4;
          e.wreg = 1;
        end
        OPC_JAL: begin
          e.alu = ALU_LINK;
          fmt = 5;
          e.wreg = 1;
          jal = 1;
        end
        OPC_JALR: begin
          e.alu = ALU_LINK;
          fmt = 1;
          e.wreg = 1;
          e.rs1r = 1;
          jalr = 1;
        end
        OPC_BRANCH: begin
          e.alu = ALU_ADD;
          fmt = 3;
          e.rs1r = 1;
          e.rs2r = 1;
          br = 1;
        end
        OPC_LOAD: begin
          e.alu = ALU_ADD;
          e.src2 = 1;
          fmt = 1;
          e.wreg = 1;
          e.rs1r = 1;
          e.memrd = 1;
          e.mem2reg = 1;
        end
        OPC_STORE: begin
          e.alu = ALU_ADD;
          e.src2 = 1;
          fmt = 2;
          e.rs1r = 1;
          e.rs2r = 1;
          e.memwr = 1;
        end
        OPC_OPIMM: begin
          e.alu = alu_of(inst[14:12], inst[30], 1'b0);
          e.src2 = 1;
          fmt = 1;
          e.wreg = 1;
          e.rs1r = 1;
        end
        OPC_OP: begin
          if (!inst[25]) begin  // M-extension stays a no-op
            e.alu = alu_of(inst[14:12], inst[30], 1'b1);
            e.wreg = 1;
            e.rs1r = 1;
            e.rs2r = 1;
          end
        end
        default: ;
      endcase
    end
    case (fmt)
      1: e.imm = {{20{inst[31]}}, inst[31:20]};
      2: e.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      3: e.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      4: e.imm = {inst[31:12], 12'h000};
      5: e.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      default: e.imm = '0;
    endcase
    e.rs1a = e.rs1r ? inst[19:15] : '0;
    e.rs2a = e.rs2r ? inst[24:20] : '0;
    e.rd   = e.wreg ? inst[11:7] : '0;
    e.rs1d = operand(e.rs1r, e.rs1a, rf_rs1_data_i);
    e.rs2d = operand(e.rs2r, e.rs2a, rf_rs2_data_i);
    e.stall = load_use(e.rs1r, e.rs1a) | load_use(e.rs2r, e.rs2a);
    case (inst[14:12])
      F3_BEQ:  cond = e.rs1d == e.rs2d;
      F3_BNE:  cond = e.rs1d != e.rs2d;
      F3_BLT:  cond = $signed(e.rs1d) < $signed(e.rs2d);
      F3_BGE:  cond = $signed(e.rs1d) >= $signed(e.rs2d);
      F3_BLTU: cond = e.rs1d < e.rs2d;
      F3_BGEU: cond = e.rs1d >= e.rs2d;
      default: cond = 0;
    endcase
    e.taken  = jal || jalr || (br && cond);
    e.target = jalr ? e.rs1d + e.imm : ((jal || br) ? pc + e.imm : '0);
    e.link   = (jal || jalr) ? pc + PC_STEP : '0;
    return e;
  endfunction

  task automatic check(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errs++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Inputs are settled at the falling edge
  always @(negedge clk_i) begin
    if (!arst_n_i) begin
      squash_m = 0;
      q = '{default: '0};
      check("ex_valid in reset", ex_valid_o, 0);
      check("ex_wreg in reset", ex_wreg_o, 0);
      check("ex_memrd in reset", ex_memrd_o, 0);
      check("ex_memwr in reset", ex_memwr_o, 0);
    end else begin
      check("ex_valid", ex_valid_o, q.valid);
      check("ex_alu_op", ex_alu_op_o, q.alu);
      check("ex_src1", ex_src1_o, q.src1);
      check("ex_src2", ex_src2_o, q.src2);
      check("ex_wreg", ex_wreg_o, q.wreg);
      check("ex_memrd", ex_memrd_o, q.memrd);
      check("ex_memwr", ex_memwr_o, q.memwr);
      check("ex_mem2reg", ex_mem2reg_o, q.mem2reg);
      if (q.valid) begin
        check("ex_imm", ex_imm_o, q.imm);
        check("ex_rs1_data", ex_rs1_data_o, q.rs1d);
        check("ex_rs2_data", ex_rs2_data_o, q.rs2d);
        check("ex_rd", ex_rd_o, q.rd);
        check("ex_funct3", ex_funct3_o, q.f3);
        check("ex_link", ex_link_o, q.link);
      end
      cur = reference(inst_i, pc_i, squash_m);
      check("rf_rs1_addr", rf_rs1_addr_o, cur.rs1a);
      check("rf_rs2_addr", rf_rs2_addr_o, cur.rs2a);
      check("rf_rs1_read", rf_rs1_read_o, cur.rs1r);
      check("rf_rs2_read", rf_rs2_read_o, cur.rs2r);
      check("stall", stall_o, cur.stall);
      check("branch_taken", branch_taken_o, cur.taken && in_valid_i);
      check("branch_target", branch_target_o, cur.target);
      accept = in_valid_i && !cur.stall;
      q = accept ? cur : '{default: '0};
      q.valid = accept && !squash_m;
      if (accept) squash_m = cur.taken;
    end
  end

endmodule

// File: id_operand_fwd.sv
`timescale 1ns/1ps

module id_operand_fwd import id_pkg::*; (
  input  logic      read_i,
  input  reg_addr_t addr_i,
  input  word_t     rf_data_i,
  bypass_if.dst     ex_i,
  bypass_if.dst     mem_i,
  output word_t     data_o,
  output logic      load_use_o
);

  logic ex_hit;
  logic mem_hit;

  // x0 is never forwarded
  assign ex_hit  = ex_i.wreg && (ex_i.rd != '0) && (ex_i.rd == addr_i);
  assign mem_hit = mem_i.wreg && (mem_i.rd != '0) && (mem_i.rd == addr_i);

  always_comb begin
    if (!read_i) begin
      data_o = '0;
    end else if (ex_hit) begin
      data_o = ex_i.data;   // Youngest result wins
    end else if (mem_hit) begin
      data_o = mem_i.data;
    end else begin
      data_o = rf_data_i;
    end
  end

  // Load data not yet available in either stage
  assign load_use_o = read_i &&
                      ((ex_i.wreg && ex_i.memrd && (ex_i.rd == addr_i)) ||
                       (mem_i.wreg && mem_i.memrd && (mem_i.rd == addr_i)));

endmodule

// File: id_pkg.sv
package id_pkg;

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   word_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by inst[30]
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LINK
  } alu_op_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_NONE} imm_fmt_e;

  typedef enum logic {SRC1_REG, SRC1_PC} src1_e;
  typedef enum logic {SRC2_REG, SRC2_IMM} src2_e;

  typedef struct packed {
    alu_op_e  alu_op;
    src1_e    src1;
    src2_e    src2;
    imm_fmt_e imm_fmt;
    logic     wreg;
    logic     memrd;
    logic     memwr;
    logic     mem2reg;
    logic     rs1_rd;
    logic     rs2_rd;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
  } ctrl_t;

  localparam word_t PC_STEP = 32'd4;

endpackage

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic       clk_i,
  input  logic       arst_n_i,
  input  logic       in_valid_i,
  input  word_t      pc_i,
  input  word_t      inst_i,
  input  word_t      rf_rs1_data_i,
  input  word_t      rf_rs2_data_i,
  output reg_addr_t  rf_rs1_addr_o,
  output reg_addr_t  rf_rs2_addr_o,
  output logic       rf_rs1_read_o,
  output logic       rf_rs2_read_o,
  input  logic       ex_wreg_i,
  input  reg_addr_t  ex_rd_i,
  input  word_t      ex_data_i,
  input  logic       ex_memrd_i,
  input  logic       mem_wreg_i,
  input  reg_addr_t  mem_rd_i,
  input  word_t      mem_data_i,
  input  logic       mem_memrd_i,
  output logic       stall_o,
  output logic       branch_taken_o,
  output word_t      branch_target_o,
  output logic       ex_valid_o,
  output alu_op_e    ex_alu_op_o,
  output src1_e      ex_src1_o,
  output src2_e      ex_src2_o,
  output word_t      ex_imm_o,
  output word_t      ex_rs1_data_o,
  output word_t      ex_rs2_data_o,
  output reg_addr_t  ex_rd_o,
  output logic       ex_wreg_o,
  output logic       ex_memrd_o,
  output logic       ex_memwr_o,
  output logic       ex_mem2reg_o,
  output logic [2:0] ex_funct3_o,
  output word_t      ex_link_o
);

  ctrl_t     ctrl;
  reg_addr_t rs1_idx;
  reg_addr_t rs2_idx;
  reg_addr_t rd_idx;
  word_t     imm;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     link;
  logic      lu_rs1;
  logic      lu_rs2;
  logic      br_taken;
  logic      accept;
  logic      squash_q; // Next accepted instruction is dropped

  bypass_if ex_byp ();
  bypass_if mem_byp ();

  assign ex_byp.wreg   = ex_wreg_i;
  assign ex_byp.rd     = ex_rd_i;
  assign ex_byp.data   = ex_data_i;
  assign ex_byp.memrd  = ex_memrd_i;
  assign mem_byp.wreg  = mem_wreg_i;
  assign mem_byp.rd    = mem_rd_i;
  assign mem_byp.data  = mem_data_i;
  assign mem_byp.memrd = mem_memrd_i;

  id_ctrl u_ctrl (
    .inst_i   (inst_i),
    .squash_i (squash_q),
    .ctrl_o   (ctrl),
    .rs1_o    (rs1_idx),
    .rs2_o    (rs2_idx),
    .rd_o     (rd_idx)
  );

  id_imm_gen u_imm (
    .inst_i (inst_i),
    .fmt_i  (ctrl.imm_fmt),
    .imm_o  (imm)
  );

  id_operand_fwd fwd_rs1 (
    .read_i     (ctrl.rs1_rd),
    .addr_i     (rs1_idx),
    .rf_data_i  (rf_rs1_data_i),
    .ex_i       (ex_byp),
    .mem_i      (mem_byp),
    .data_o     (rs1_data),
    .load_use_o (lu_rs1)
  );

  id_operand_fwd fwd_rs2 (
    .read_i     (ctrl.rs2_rd),
    .addr_i     (rs2_idx),
    .rf_data_i  (rf_rs2_data_i),
    .ex_i       (ex_byp),
    .mem_i      (mem_byp),
    .data_o     (rs2_data),
    .load_use_o (lu_rs2)
  );

  id_branch_unit u_branch (
    .ctrl_i   (ctrl),
    .funct3_i (inst_i[14:12]),
    .pc_i     (pc_i),
    .rs1_i    (rs1_data),
    .rs2_i    (rs2_data),
    .imm_i    (imm),
    .taken_o  (br_taken),
    .target_o (branch_target_o),
    .link_o   (link)
  );

  assign rf_rs1_addr_o  = rs1_idx;
  assign rf_rs2_addr_o  = rs2_idx;
  assign rf_rs1_read_o  = ctrl.rs1_rd;
  assign rf_rs2_read_o  = ctrl.rs2_rd;
  assign stall_o        = lu_rs1 | lu_rs2;
  assign branch_taken_o = in_valid_i & br_taken;
  assign accept         = in_valid_i & ~stall_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      squash_q     <= 1'b0;
      ex_valid_o   <= 1'b0;
      ex_alu_op_o  <= ALU_NONE;
      ex_src1_o    <= SRC1_REG;
      ex_src2_o    <= SRC2_REG;
      ex_wreg_o    <= 1'b0;
      ex_memrd_o   <= 1'b0;
      ex_memwr_o   <= 1'b0;
      ex_mem2reg_o <= 1'b0;
    end else begin
      if (accept) begin
        squash_q <= br_taken; // Squashed slot has no taken, so this clears
      end
      ex_valid_o <= accept & ~squash_q;
      if (accept) begin
        // ctrl is already inactive for a squashed slot
        ex_alu_op_o  <= ctrl.alu_op;
        ex_src1_o    <= ctrl.src1;
        ex_src2_o    <= ctrl.src2;
        ex_wreg_o    <= ctrl.wreg;
        ex_memrd_o   <= ctrl.memrd;
        ex_memwr_o   <= ctrl.memwr;
        ex_mem2reg_o <= ctrl.mem2reg;
      end else begin
        ex_alu_op_o  <= ALU_NONE; // Bubble
        ex_src1_o    <= SRC1_REG;
        ex_src2_o    <= SRC2_REG;
        ex_wreg_o    <= 1'b0;
        ex_memrd_o   <= 1'b0;
        ex_memwr_o   <= 1'b0;
        ex_mem2reg_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ex_imm_o      <= imm;
      ex_rs1_data_o <= rs1_data;
      ex_rs2_data_o <= rs2_data;
      ex_rd_o       <= rd_idx;
      ex_funct3_o   <= inst_i[14:12];
      ex_link_o     <= link;
    end
  end

endmodule

// File: id_stage_chk.sv
`timescale 1ns/1ps

module id_stage_chk (
  input logic clk_i,
  input logic arst_n_i,
  input logic in_valid_i,
  input logic squash_i,
  input logic stall_o,
  input logic branch_taken_o,
  input logic ex_valid_o,
  input logic ex_wreg_o,
  input logic ex_memrd_o,
  input logic ex_memwr_o
);

  int fail_cnt = 0;

  // A stalled cycle leaves a bubble
  a_stall_bubble: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_o |=> !ex_valid_o)
    else begin
      $error("stall not followed by a bubble");
      fail_cnt++;
    end

  a_reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !(ex_valid_o || ex_wreg_o || ex_memrd_o || ex_memwr_o))
    else begin
      $error("ID/EX controls active during reset");
      fail_cnt++;
    end

  // Squashed slot never redirects
  a_taken_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    branch_taken_o |-> (in_valid_i && !squash_i))
    else begin
      $error("branch taken without a valid unsquashed instruction");
      fail_cnt++;
    end

endmodule

bind id_stage id_stage_chk chk (.*, .squash_i(squash_q));

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage import id_pkg::*; ();

  // Issue slots per test, load-use stalls, reset test and idle tails
  localparam int TEST_CYCLES = 5 + 34 + 24 + 16 + 20 + 60 + 15 + 6 * 2;

  logic clk_i, arst_n_i, in_valid_i;
  word_t pc_i, inst_i, rf_rs1_data_i, rf_rs2_data_i, ex_data_i, mem_data_i;
  logic ex_wreg_i, ex_memrd_i, mem_wreg_i, mem_memrd_i;
  reg_addr_t ex_rd_i, mem_rd_i, rf_rs1_addr_o, rf_rs2_addr_o, ex_rd_o;
  logic rf_rs1_read_o, rf_rs2_read_o, stall_o, branch_taken_o, ex_valid_o;
  word_t branch_target_o, ex_imm_o, ex_rs1_data_o, ex_rs2_data_o, ex_link_o;
  alu_op_e ex_alu_op_o;
  src1_e ex_src1_o;
  src2_e ex_src2_o;
  logic ex_wreg_o, ex_memrd_o, ex_memwr_o, ex_mem2reg_o;
  logic [2:0] ex_funct3_o;

  word_t pc_next;
  int    err_mark = 0;
  int    passed = 0;
  int    failed = 0;
  logic [2:0] br_f3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  id_stage dut (.*);
  id_monitor mon (.*);

  initial begin
    clk_i = 0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #(TEST_CYCLES * 2 * 8);
    $display("The run timed out before all tests finished");
    $display("RESULT: FAIL");
    $finish;
  end

  function automatic reg_addr_t rand_reg();
    return reg_addr_t'($urandom());
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                  reg_addr_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                  logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic randomize_side();
    rf_rs1_data_i <= $urandom();
    rf_rs2_data_i <= $urandom();
    ex_wreg_i     <= $urandom();
    ex_rd_i       <= rand_reg();
    ex_data_i     <= $urandom();
    ex_memrd_i    <= ($urandom() % 8) == 0;
    mem_wreg_i    <= $urandom();
    mem_rd_i      <= rand_reg();
    mem_data_i    <= $urandom();
    mem_memrd_i   <= ($urandom() % 8) == 0;
  endtask

  // Targeted side values override the random ones
  task automatic force_side(int mode, word_t inst);
    word_t v;
    v = $urandom();
    case (mode)
      1: begin
        ex_wreg_i  <= 1;
        ex_memrd_i <= 1;
        ex_rd_i    <= inst[19:15];
      end
      2: begin
        ex_wreg_i  <= 1;
        ex_memrd_i <= 0;
        ex_rd_i    <= inst[19:15];
        mem_wreg_i <= 1;
        mem_memrd_i <= 0;
        mem_rd_i   <= inst[19:15];
      end
      3: begin
        ex_wreg_i   <= 0;
        mem_wreg_i  <= 1;
        mem_memrd_i <= 0;
        mem_rd_i    <= inst[24:20];
      end
      4: begin
        ex_wreg_i   <= 1;
        ex_memrd_i  <= 0;
        ex_rd_i     <= '0;
        mem_wreg_i  <= 1;
        mem_memrd_i <= 0;
        mem_rd_i    <= '0;
      end
      5: begin
        ex_wreg_i     <= 0;
        mem_wreg_i    <= 0;
        rf_rs1_data_i <= v;
        rf_rs2_data_i <= v;
      end
      6: begin
        ex_wreg_i   <= 0;
        mem_wreg_i  <= 1;
        mem_memrd_i <= 1;
        mem_rd_i    <= inst[24:20];
      end
      default: ;
    endcase
  endtask

  // Present one instruction and hold it until the stage takes it
  task automatic issue(word_t inst, int mode);
    @(posedge clk_i);
    in_valid_i <= 1;
    inst_i     <= inst;
    pc_i       <= pc_next;
    pc_next    += 4;
    randomize_side();
    force_side(mode, inst);
    @(negedge clk_i);
    while (stall_o) begin
      @(posedge clk_i);
      randomize_side();
      @(negedge clk_i);
    end
  endtask

  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk_i);
      in_valid_i <= 0;
      inst_i     <= $urandom();
      randomize_side();
    end
  endtask

  function automatic int total_errs();
    return mon.errs + dut.chk.fail_cnt;
  endfunction

  task automatic end_test(string name);
    int e;
    idle(2);
    e = total_errs() - err_mark;
    err_mark = total_errs();
    if (e == 0) passed++;
    else failed++;
    $display("test %s: %s, %0d errors", name, (e == 0) ? "ok" : "failed", e);
  endtask

  initial begin
    void'($urandom(32'h48ec91be));
    arst_n_i = 0;
    in_valid_i = 0;
    pc_i = '0;
    inst_i = '0;
    rf_rs1_data_i = '0;
    rf_rs2_data_i = '0;
    ex_wreg_i = 0;
    ex_rd_i = '0;
    ex_data_i = '0;
    ex_memrd_i = 0;
    mem_wreg_i = 0;
    mem_rd_i = '0;
    mem_data_i = '0;
    mem_memrd_i = 0;
    pc_next = $urandom() & 32'hffff_fffc;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1;

    for (int f = 0; f < 8; f++) begin
      issue(enc_r(7'h00, rand_reg(), rand_reg(), f[2:0], rand_reg(), OPC_OP), 0);
      issue(enc_r(7'h20, rand_reg(), rand_reg(), f[2:0], rand_reg(), OPC_OP), 0);
      issue(enc_i($urandom(), rand_reg(), f[2:0], rand_reg(), OPC_OPIMM), 0);
      // Multiply group
      issue(enc_r(7'h01, rand_reg(), rand_reg(), f[2:0], rand_reg(), OPC_OP), 0);
    end
    issue(enc_i(12'h0ff, 5'd0, 3'd0, 5'd0, 7'b0001111), 0);  // FENCE
    issue(enc_i(12'h000, 5'd0, 3'd0, 5'd0, 7'b1110011), 0);  // ECALL
    end_test("alu_decode");

    repeat (6) begin
      issue({20'($urandom()), rand_reg(), OPC_LUI}, 0);
      issue({20'($urandom()), rand_reg(), OPC_AUIPC}, 0);
      issue(enc_i($urandom(), rand_reg(), 3'd2, rand_reg(), OPC_LOAD), 0);
      issue(enc_s($urandom(), rand_reg(), rand_reg(), 3'd2), 0);
    end
    end_test("imm_and_mem");

    repeat (4) begin
      issue(enc_r(7'h00, rand_reg(), rand_reg(), F3_ADD, rand_reg(), OPC_OP), 2);
      issue(enc_r(7'h00, rand_reg(), rand_reg(), F3_XOR, rand_reg(), OPC_OP), 3);
      issue(enc_r(7'h00, 5'd0, 5'd0, F3_OR, rand_reg(), OPC_OP), 4);
      issue({20'($urandom()), rand_reg(), OPC_LUI}, 2); // rs1 field not read
    end
    end_test("forwarding");

    repeat (4) begin
      issue(enc_i($urandom(), rand_reg(), 3'd2, rand_reg(), OPC_LOAD), 0);
      issue(enc_r(7'h00, rand_reg(), rand_reg(), F3_ADD, rand_reg(), OPC_OP), 1);
      issue(enc_s($urandom(), rand_reg(), rand_reg(), 3'd2), 6);
    end
    end_test("load_use");

    for (int i = 0; i < 24; i++) begin
      issue(enc_b($urandom() & 13'h1ffe, rand_reg(), rand_reg(), br_f3[i % 6]),
            (i / 6) % 2 ? 5 : 0);
      issue(enc_r(7'h00, rand_reg(), rand_reg(), F3_ADD, rand_reg(), OPC_OP), 0);
    end
    repeat (3) begin
      issue(enc_j($urandom() & 21'h1ffffe, rand_reg()), 0);
      issue(enc_r(7'h00, rand_reg(), rand_reg(), F3_ADD, rand_reg(), OPC_OP), 0);
      issue(enc_i($urandom(), rand_reg(), 3'd0, rand_reg(), OPC_JALR), 0);
      issue(enc_i($urandom(), rand_reg(), 3'd2, rand_reg(), OPC_LOAD), 0);
    end
    end_test("branch_jump");

    idle(6);
    @(posedge clk_i);
    arst_n_i <= 0;
    idle(3);
    @(posedge clk_i);
    arst_n_i <= 1;
    idle(4);
    end_test("reset_idle");

    $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
             passed + failed, passed, failed, mon.checks, total_errs());
    if (failed == 0 && total_errs() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
